// ==== Bender.yml ====
package:
  name: cce

sources:
  - cce_pkg.sv
  - cce_dir_if.sv
  - cce_dir.sv
  - cce_gad.sv
  - cce_msg.sv
  - cce_ctrl.sv
  - cce.sv
  - target: simulation
    files:
      - cce_tb.sv

// ==== cce.f ====
cce_pkg.sv
cce_dir_if.sv
cce_dir.sv
cce_gad.sv
cce_msg.sv
cce_ctrl.sv
cce.sv
cce_tb.sv

// ==== cce.sv ====
// Cache coherence engine top level. Serves one LCE request at a time:
// directory lookup, sharer commands, optional memory read, then set-state.
// Inbound ports are valid->yumi, outbound ports are ready&valid.

`timescale 1ns/1ps

module cce #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS,
  localparam int lce_id_width = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,

  input  logic                             lce_req_v_i,
  input  logic [lce_id_width-1:0]          lce_req_lce_i,
  input  logic [cce_pkg::PADDR_WIDTH-1:0]  lce_req_addr_i,
  input  logic                             lce_req_write_i,
  input  logic [way_width-1:0]             lce_req_lru_way_i,
  output logic                             lce_req_yumi_o,

  output logic                             lce_cmd_v_o,
  output cce_pkg::lce_cmd_type_e           lce_cmd_type_o,
  output logic [lce_id_width-1:0]          lce_cmd_lce_o,
  output logic [cce_pkg::PADDR_WIDTH-1:0]  lce_cmd_addr_o,
  output logic [way_width-1:0]             lce_cmd_way_o,
  output cce_pkg::coh_state_e              lce_cmd_state_o,
  input  logic                             lce_cmd_ready_i,

  output logic                             mem_cmd_v_o,
  output logic [cce_pkg::PADDR_WIDTH-1:0]  mem_cmd_addr_o,
  input  logic                             mem_cmd_ready_i,
  input  logic                             mem_resp_v_i,
  output logic                             mem_resp_yumi_o
);
  import cce_pkg::*;

  logic                    req_hit, req_write, msg_start, need_mem, msg_done;
  logic [way_width-1:0]    req_way, req_lru_way;
  logic [lce_id_width-1:0] req_lce;
  logic [PADDR_WIDTH-1:0]  req_addr;
  logic [num_lce_p-1:0]    inv_mask, down_mask;
  coh_state_e              next_state;

  cce_dir_if #(
    .num_lce_p(num_lce_p), .lce_assoc_p(lce_assoc_p), .lce_sets_p(lce_sets_p)
  ) dir_if ();

  cce_ctrl #(
    .num_lce_p(num_lce_p), .lce_assoc_p(lce_assoc_p), .lce_sets_p(lce_sets_p)
  ) u_ctrl (
    .clk_i, .arst_n_i,
    .lce_req_v_i, .lce_req_lce_i, .lce_req_addr_i, .lce_req_write_i,
    .lce_req_lru_way_i, .lce_req_yumi_o,
    .dir_if(dir_if.ctrl),
    .req_hit_i(req_hit), .req_way_i(req_way), .next_state_i(next_state),
    .inv_mask_i(inv_mask), .down_mask_i(down_mask),
    .msg_done_i(msg_done), .msg_start_o(msg_start), .need_mem_o(need_mem),
    .req_lce_o(req_lce), .req_addr_o(req_addr), .req_write_o(req_write),
    .req_lru_way_o(req_lru_way)
  );

  cce_dir #(
    .num_lce_p(num_lce_p), .lce_assoc_p(lce_assoc_p), .lce_sets_p(lce_sets_p)
  ) u_dir (
    .clk_i, .arst_n_i, .dir_if(dir_if.dir)
  );

  cce_gad #(
    .num_lce_p(num_lce_p), .lce_assoc_p(lce_assoc_p), .lce_sets_p(lce_sets_p)
  ) u_gad (
    .dir_if(dir_if.gad),
    .req_lce_i(req_lce), .req_write_i(req_write), .lru_way_i(req_lru_way),
    .req_hit_o(req_hit), .req_way_o(req_way), .next_state_o(next_state),
    .inv_mask_o(inv_mask), .down_mask_o(down_mask)
  );

  cce_msg #(
    .num_lce_p(num_lce_p), .lce_assoc_p(lce_assoc_p), .lce_sets_p(lce_sets_p)
  ) u_msg (
    .clk_i, .arst_n_i, .dir_if(dir_if.gad),
    .msg_start_i(msg_start), .need_mem_i(need_mem),
    .req_lce_i(req_lce), .req_addr_i(req_addr), .req_way_i(req_way),
    .next_state_i(next_state), .inv_mask_i(inv_mask), .down_mask_i(down_mask),
    .msg_done_o(msg_done),
    .lce_cmd_v_o, .lce_cmd_type_o, .lce_cmd_lce_o, .lce_cmd_addr_o,
    .lce_cmd_way_o, .lce_cmd_state_o, .lce_cmd_ready_i,
    .mem_cmd_v_o, .mem_cmd_addr_o, .mem_cmd_ready_i,
    .mem_resp_v_i, .mem_resp_yumi_o
  );

endmodule

// ==== cce_ctrl.sv ====
// Request control FSM. Accepts one LCE request at a time, reads the
// directory, starts the message unit and writes the directory back
// once the requester's set-state command has gone out.

`timescale 1ns/1ps

module cce_ctrl #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS,
  localparam int lce_id_width = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             lce_req_v_i,
  input  logic [lce_id_width-1:0]          lce_req_lce_i,
  input  logic [cce_pkg::PADDR_WIDTH-1:0]  lce_req_addr_i,
  input  logic                             lce_req_write_i,
  input  logic [way_width-1:0]             lce_req_lru_way_i,
  output logic                             lce_req_yumi_o,
  cce_dir_if.ctrl                          dir_if,
  input  logic                             req_hit_i,
  input  logic [way_width-1:0]             req_way_i,
  input  cce_pkg::coh_state_e              next_state_i,
  input  logic [num_lce_p-1:0]             inv_mask_i,
  input  logic [num_lce_p-1:0]             down_mask_i,
  input  logic                             msg_done_i,
  output logic                             msg_start_o,
  output logic                             need_mem_o,
  output logic [lce_id_width-1:0]          req_lce_o,
  output logic [cce_pkg::PADDR_WIDTH-1:0]  req_addr_o,
  output logic                             req_write_o,
  output logic [way_width-1:0]             req_lru_way_o
);
  import cce_pkg::*;

  localparam int set_width    = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1;
  localparam int offset_width = $clog2(BLOCK_BYTES);
  localparam int tag_width    = PADDR_WIDTH - set_width - offset_width;

  typedef enum logic [1:0] {
    e_idle,
    e_lookup,
    e_message,
    e_update
  } ctrl_state_e;

  ctrl_state_e             state_r;
  logic [lce_id_width-1:0] req_lce_r;
  logic [PADDR_WIDTH-1:0]  req_addr_r;
  logic                    req_write_r;
  logic [way_width-1:0]    req_lru_r;
  logic [PADDR_WIDTH-1:0]  dir_addr;

  assign lce_req_yumi_o = (state_r == e_idle) & lce_req_v_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= e_idle;
    end else begin
      case (state_r)
        e_idle: begin
          if (lce_req_v_i) begin
            state_r <= e_lookup;
          end
        end
        e_lookup: begin
          if (dir_if.sharers_v) begin
            state_r <= e_message;
          end
        end
        e_message: begin
          if (msg_done_i) begin
            state_r <= e_update;
          end
        end
        default: state_r <= e_idle;
      endcase
    end
  end

  // Request register
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      req_lce_r   <= lce_req_lce_i;
      req_addr_r  <= lce_req_addr_i;
      req_write_r <= lce_req_write_i;
      req_lru_r   <= lce_req_lru_way_i;
    end
  end

  // Read uses the live request, the later write uses the captured one
  assign dir_addr = (state_r == e_idle) ? lce_req_addr_i : req_addr_r;

  assign dir_if.r_v       = lce_req_yumi_o;
  assign dir_if.set       = dir_addr[offset_width +: set_width];
  assign dir_if.tag       = dir_addr[PADDR_WIDTH-1 -: tag_width];
  assign dir_if.w_v       = (state_r == e_update);
  assign dir_if.w_lce     = req_lce_r;
  assign dir_if.w_way     = req_way_i;
  assign dir_if.w_state   = next_state_i;
  assign dir_if.inv_mask  = inv_mask_i;
  assign dir_if.down_mask = down_mask_i;

  assign msg_start_o = (state_r == e_lookup) & dir_if.sharers_v;
  assign need_mem_o  = ~req_hit_i;

  assign req_lce_o     = req_lce_r;
  assign req_addr_o    = req_addr_r;
  assign req_write_o   = req_write_r;
  assign req_lru_way_o = req_lru_r;

endmodule

// ==== cce_dir.sv ====
// Coherence directory. Holds tag and state per LCE, set and way, and
// returns the sharers of a block one cycle after a read request.
// A write updates the requester entry and applies invalidates/downgrades.

`timescale 1ns/1ps

module cce_dir #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS
) (
  input logic      clk_i,
  input logic      arst_n_i,
  cce_dir_if.dir   dir_if
);
  import cce_pkg::*;

  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1;
  localparam int set_width    = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1;
  localparam int offset_width = $clog2(BLOCK_BYTES);
  localparam int tag_width    = PADDR_WIDTH - set_width - offset_width;

  logic [tag_width-1:0] tag_r   [num_lce_p][lce_sets_p][lce_assoc_p];
  coh_state_e           state_r [num_lce_p][lce_sets_p][lce_assoc_p];

  logic                                sharers_v_r;
  logic [num_lce_p-1:0]                hits_r, hits_n;
  logic [num_lce_p-1:0][way_width-1:0] ways_r, ways_n;
  coh_state_e [num_lce_p-1:0]          states_r, states_n;

  // Tag match per LCE, lowest matching way wins
  always_comb begin
    for (int l = 0; l < num_lce_p; l++) begin
      hits_n[l]   = 1'b0;
      ways_n[l]   = '0;
      states_n[l] = e_coh_i;
      for (int w = lce_assoc_p - 1; w >= 0; w--) begin
        if (state_r[l][dir_if.set][w] != e_coh_i && tag_r[l][dir_if.set][w] == dir_if.tag) begin
          hits_n[l]   = 1'b1;
          ways_n[l]   = way_width'(w);
          states_n[l] = state_r[l][dir_if.set][w];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sharers_v_r <= 1'b0;
    end else begin
      sharers_v_r <= dir_if.r_v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dir_if.r_v) begin
      hits_r   <= hits_n;
      ways_r   <= ways_n;
      states_r <= states_n;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= '{default: e_coh_i};
    end else if (dir_if.w_v) begin
      // Sharer updates use the ways found by the last lookup
      for (int l = 0; l < num_lce_p; l++) begin
        if (dir_if.inv_mask[l]) begin
          state_r[l][dir_if.set][ways_r[l]] <= e_coh_i;
        end else if (dir_if.down_mask[l]) begin
          state_r[l][dir_if.set][ways_r[l]] <= e_coh_s;
        end
      end
      state_r[dir_if.w_lce][dir_if.set][dir_if.w_way] <= dir_if.w_state;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dir_if.w_v) begin
      tag_r[dir_if.w_lce][dir_if.set][dir_if.w_way] <= dir_if.tag;
    end
  end

  assign dir_if.sharers_v      = sharers_v_r;
  assign dir_if.sharers_hits   = hits_r;
  assign dir_if.sharers_ways   = ways_r;
  assign dir_if.sharers_states = states_r;

endmodule

// ==== cce_dir_if.sv ====
// Directory access bundle between the CCE control FSM, the directory,
// the GAD logic and the message unit.

`timescale 1ns/1ps

interface cce_dir_if #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS
);
  import cce_pkg::*;

  localparam int lce_id_width = (num_lce_p > 1) ? $clog2(num_lce_p) : 1;
  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1;
  localparam int set_width    = (lce_sets_p > 1) ? $clog2(lce_sets_p) : 1;
  localparam int offset_width = $clog2(BLOCK_BYTES);
  localparam int tag_width    = PADDR_WIDTH - set_width - offset_width;

  // Read request
  logic                 r_v;
  logic [set_width-1:0] set;
  logic [tag_width-1:0] tag;

  // Write request, requester entry plus sharer updates
  logic                    w_v;
  logic [lce_id_width-1:0] w_lce;
  logic [way_width-1:0]    w_way;
  coh_state_e              w_state;
  logic [num_lce_p-1:0]    inv_mask;
  logic [num_lce_p-1:0]    down_mask;

  // Registered lookup results
  logic                                sharers_v;
  logic [num_lce_p-1:0]                sharers_hits;
  logic [num_lce_p-1:0][way_width-1:0] sharers_ways;
  coh_state_e [num_lce_p-1:0]          sharers_states;

  modport ctrl (
    output r_v, set, tag, w_v, w_lce, w_way, w_state, inv_mask, down_mask,
    input  sharers_v
  );

  modport dir (
    input  r_v, set, tag, w_v, w_lce, w_way, w_state, inv_mask, down_mask,
    output sharers_v, sharers_hits, sharers_ways, sharers_states
  );

  modport gad (
    input sharers_v, sharers_hits, sharers_ways, sharers_states
  );

endinterface

// ==== cce_gad.sv ====
// Sharer analysis. Combinational on the registered directory lookup;
// decides which other LCEs are invalidated or downgraded, the requester's
// next state and whether the requester already holds the block.

`timescale 1ns/1ps

module cce_gad #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS,
  localparam int lce_id_width = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  cce_dir_if.gad                  dir_if,
  input  logic [lce_id_width-1:0] req_lce_i,
  input  logic                    req_write_i,
  input  logic [way_width-1:0]    lru_way_i,
  output logic                    req_hit_o,
  output logic [way_width-1:0]    req_way_o,
  output cce_pkg::coh_state_e     next_state_o,
  output logic [num_lce_p-1:0]    inv_mask_o,
  output logic [num_lce_p-1:0]    down_mask_o
);
  import cce_pkg::*;

  logic [num_lce_p-1:0] others;
  logic [num_lce_p-1:0] remaining;

  always_comb begin
    others = dir_if.sharers_hits;
    others[req_lce_i] = 1'b0;
    for (int l = 0; l < num_lce_p; l++) begin
      // M holders lose the block on any request since there is no data transfer
      inv_mask_o[l]  = others[l] & (req_write_i | dir_if.sharers_states[l] == e_coh_m);
      down_mask_o[l] = others[l] & ~req_write_i & (dir_if.sharers_states[l] == e_coh_e);
    end
  end

  // Holders still valid once the invalidates are done
  assign remaining = others & ~inv_mask_o;

  assign req_hit_o = dir_if.sharers_hits[req_lce_i];
  assign req_way_o = req_hit_o ? dir_if.sharers_ways[req_lce_i] : lru_way_i;

  always_comb begin
    if (req_write_i) begin
      next_state_o = e_coh_m;
    end else if (|remaining) begin
      next_state_o = e_coh_s;
    end else begin
      next_state_o = e_coh_e;
    end
  end

endmodule

// ==== cce_msg.sv ====
// Message unit. Started once per request by the control FSM; sends the
// sharer commands in ascending LCE order, then the memory read if needed,
// then the requester's set-state command, and pulses msg_done_o.

`timescale 1ns/1ps

module cce_msg #(
  parameter int num_lce_p   = cce_pkg::NUM_LCE,
  parameter int lce_assoc_p = cce_pkg::LCE_ASSOC,
  parameter int lce_sets_p  = cce_pkg::LCE_SETS,
  localparam int lce_id_width = (num_lce_p > 1) ? $clog2(num_lce_p) : 1,
  localparam int way_width    = (lce_assoc_p > 1) ? $clog2(lce_assoc_p) : 1
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  cce_dir_if.gad                           dir_if,
  input  logic                             msg_start_i,
  input  logic                             need_mem_i,
  input  logic [lce_id_width-1:0]          req_lce_i,
  input  logic [cce_pkg::PADDR_WIDTH-1:0]  req_addr_i,
  input  logic [way_width-1:0]             req_way_i,
  input  cce_pkg::coh_state_e              next_state_i,
  input  logic [num_lce_p-1:0]             inv_mask_i,
  input  logic [num_lce_p-1:0]             down_mask_i,
  output logic                             msg_done_o,
  output logic                             lce_cmd_v_o,
  output cce_pkg::lce_cmd_type_e           lce_cmd_type_o,
  output logic [lce_id_width-1:0]          lce_cmd_lce_o,
  output logic [cce_pkg::PADDR_WIDTH-1:0]  lce_cmd_addr_o,
  output logic [way_width-1:0]             lce_cmd_way_o,
  output cce_pkg::coh_state_e              lce_cmd_state_o,
  input  logic                             lce_cmd_ready_i,
  output logic                             mem_cmd_v_o,
  output logic [cce_pkg::PADDR_WIDTH-1:0]  mem_cmd_addr_o,
  input  logic                             mem_cmd_ready_i,
  input  logic                             mem_resp_v_i,
  output logic                             mem_resp_yumi_o
);
  import cce_pkg::*;

  localparam int offset_width = $clog2(BLOCK_BYTES);

  typedef enum logic [2:0] {
    e_msg_idle,
    e_msg_sharers,
    e_msg_mem_cmd,
    e_msg_mem_resp,
    e_msg_set_state
  } msg_state_e;

  msg_state_e              state_r;
  logic [num_lce_p-1:0]    inv_r, down_r, pend;
  logic                    need_mem_r;
  logic [lce_id_width-1:0] tgt;
  logic [PADDR_WIDTH-1:0]  block_addr;

  assign pend       = inv_r | down_r;
  assign block_addr = {req_addr_i[PADDR_WIDTH-1:offset_width], {offset_width{1'b0}}};

  // Lowest pending LCE goes first
  always_comb begin
    tgt = '0;
    for (int l = num_lce_p - 1; l >= 0; l--) begin
      if (pend[l]) begin
        tgt = lce_id_width'(l);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r    <= e_msg_idle;
      inv_r      <= '0;
      down_r     <= '0;
      need_mem_r <= 1'b0;
    end else begin
      case (state_r)
        e_msg_idle: begin
          if (msg_start_i) begin
            inv_r      <= inv_mask_i;
            down_r     <= down_mask_i;
            need_mem_r <= need_mem_i;
            state_r    <= e_msg_sharers;
          end
        end
        e_msg_sharers: begin
          if (pend == '0) begin
            state_r <= need_mem_r ? e_msg_mem_cmd : e_msg_set_state;
          end else if (lce_cmd_ready_i) begin
            inv_r[tgt]  <= 1'b0;
            down_r[tgt] <= 1'b0;
          end
        end
        e_msg_mem_cmd: begin
          if (mem_cmd_ready_i) begin
            state_r <= e_msg_mem_resp;
          end
        end
        e_msg_mem_resp: begin
          if (mem_resp_v_i) begin
            state_r <= e_msg_set_state;
          end
        end
        e_msg_set_state: begin
          if (lce_cmd_ready_i) begin
            state_r <= e_msg_idle;
          end
        end
        default: state_r <= e_msg_idle;
      endcase
    end
  end

  always_comb begin
    lce_cmd_v_o     = 1'b0;
    lce_cmd_type_o  = e_cmd_set_state;
    lce_cmd_lce_o   = req_lce_i;
    lce_cmd_way_o   = req_way_i;
    lce_cmd_state_o = next_state_i;
    if (state_r == e_msg_sharers) begin
      lce_cmd_v_o   = |pend;
      lce_cmd_lce_o = tgt;
      lce_cmd_way_o = dir_if.sharers_ways[tgt];
      if (inv_r[tgt]) begin
        lce_cmd_type_o  = e_cmd_inv;
        lce_cmd_state_o = e_coh_i;
      end else begin
        lce_cmd_state_o = e_coh_s;
      end
    end else if (state_r == e_msg_set_state) begin
      lce_cmd_v_o = 1'b1;
    end
  end

  assign lce_cmd_addr_o  = block_addr;
  assign mem_cmd_v_o     = (state_r == e_msg_mem_cmd);
  assign mem_cmd_addr_o  = block_addr;
  assign mem_resp_yumi_o = (state_r == e_msg_mem_resp) & mem_resp_v_i;
  assign msg_done_o      = (state_r == e_msg_set_state) & lce_cmd_ready_i;

endmodule

// ==== cce_pkg.sv ====
// Shared types and default geometry for the cache coherence engine.
// Import into module bodies; use scoped names in module headers.

package cce_pkg;

  // Default system geometry, overridable per instance through module parameters
  parameter int NUM_LCE     = 4;
  parameter int LCE_ASSOC   = 2;
  parameter int LCE_SETS    = 8;
  parameter int PADDR_WIDTH = 16;
  parameter int BLOCK_BYTES = 8;

  // MESI state as kept in the directory and sent to the LCEs
  typedef enum logic [1:0] {
    e_coh_i = 2'b00,
    e_coh_s = 2'b01,
    e_coh_e = 2'b10,
    e_coh_m = 2'b11
  } coh_state_e;

  typedef enum logic {
    e_cmd_inv       = 1'b0,
    e_cmd_set_state = 1'b1
  } lce_cmd_type_e;

endpackage

// ==== cce_tb.sv ====
// Directed testbench for the cache coherence engine. A reference directory
// predicts every LCE and memory command of each request; the DUT output is
// compared with it command by command, with and without back-pressure.

`timescale 1ns/1ps

module cce_tb;
  import cce_pkg::*;

  localparam int lce_id_width = $clog2(NUM_LCE);
  localparam int way_width    = $clog2(LCE_ASSOC);
  localparam int set_width    = $clog2(LCE_SETS);
  localparam int offset_width = $clog2(BLOCK_BYTES);
  localparam int tag_width    = PADDR_WIDTH - set_width - offset_width;
  localparam int wait_limit   = 100;
  localparam int cmd_limit    = 400;

  typedef struct packed {
    lce_cmd_type_e           typ;
    logic [lce_id_width-1:0] lce;
    logic [way_width-1:0]    way;
    coh_state_e              st;
  } cmd_t;

  logic                    clk;
  logic                    arst_n;
  logic                    lce_req_v;
  logic [lce_id_width-1:0] lce_req_lce;
  logic [PADDR_WIDTH-1:0]  lce_req_addr;
  logic                    lce_req_write;
  logic [way_width-1:0]    lce_req_lru_way;
  logic                    lce_req_yumi;
  logic                    lce_cmd_v;
  lce_cmd_type_e           lce_cmd_type;
  logic [lce_id_width-1:0] lce_cmd_lce;
  logic [PADDR_WIDTH-1:0]  lce_cmd_addr;
  logic [way_width-1:0]    lce_cmd_way;
  coh_state_e              lce_cmd_state;
  logic                    lce_cmd_ready;
  logic                    mem_cmd_v;
  logic [PADDR_WIDTH-1:0]  mem_cmd_addr;
  logic                    mem_cmd_ready;
  logic                    mem_resp_v;
  logic                    mem_resp_yumi;

  // Reference directory
  logic [tag_width-1:0] m_tag   [NUM_LCE][LCE_SETS][LCE_ASSOC];
  coh_state_e           m_state [NUM_LCE][LCE_SETS][LCE_ASSOC];

  // What the DUT granted on the last request
  coh_state_e  got_state;
  int          got_way;
  bit          got_mem;
  int          got_cmds;

  int          errors = 0;
  int          checks = 0;
  bit          timed_out = 0;
  logic [31:0] rng = 32'd39311;

  cce #(
    .num_lce_p(NUM_LCE), .lce_assoc_p(LCE_ASSOC), .lce_sets_p(LCE_SETS)
  ) u_dut (
    .clk_i(clk), .arst_n_i(arst_n),
    .lce_req_v_i(lce_req_v), .lce_req_lce_i(lce_req_lce), .lce_req_addr_i(lce_req_addr),
    .lce_req_write_i(lce_req_write), .lce_req_lru_way_i(lce_req_lru_way),
    .lce_req_yumi_o(lce_req_yumi),
    .lce_cmd_v_o(lce_cmd_v), .lce_cmd_type_o(lce_cmd_type), .lce_cmd_lce_o(lce_cmd_lce),
    .lce_cmd_addr_o(lce_cmd_addr), .lce_cmd_way_o(lce_cmd_way),
    .lce_cmd_state_o(lce_cmd_state), .lce_cmd_ready_i(lce_cmd_ready),
    .mem_cmd_v_o(mem_cmd_v), .mem_cmd_addr_o(mem_cmd_addr), .mem_cmd_ready_i(mem_cmd_ready),
    .mem_resp_v_i(mem_resp_v), .mem_resp_yumi_o(mem_resp_yumi)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  task automatic report_error(input string name, input string what);
    errors++;
    $display("Error in %s: %s", name, what);
  endtask

  task automatic timeout_hit(input string name, input string what);
    errors++;
    timed_out = 1'b1;
    $display("Error in %s: gave up waiting for %s", name, what);
  endtask

  // One request, from the handshake to the directory update in the model
  task automatic send_request(input string name, input int lce, input logic [15:0] addr,
                              input bit write, input int lru, input bit stall);
    logic [set_width-1:0]   set;
    logic [tag_width-1:0]   tag;
    logic [PADDR_WIDTH-1:0] blk;
    bit                     hit [NUM_LCE];
    int                     hway [NUM_LCE];
    coh_state_e             hst [NUM_LCE];
    logic [NUM_LCE-1:0]     inv_m, down_m;
    bit                     others_left, need_mem, mem_acc, resp_done, done;
    bit                     lce_rdy, mem_rdy, lce_hold_v, mem_hold_v;
    coh_state_e             next;
    int                     req_way, cnt;
    cmd_t                   exp_q [$];
    cmd_t                   cur, lce_held;
    if (timed_out) return;
    set = addr[offset_width +: set_width];
    tag = addr[PADDR_WIDTH-1 -: tag_width];
    blk = {addr[PADDR_WIDTH-1:offset_width], {offset_width{1'b0}}};
    inv_m = '0;
    down_m = '0;
    others_left = 0;
    for (int l = 0; l < NUM_LCE; l++) begin
      hit[l] = 0;
      hway[l] = 0;
      hst[l] = e_coh_i;
      for (int w = 0; w < LCE_ASSOC; w++) begin
        if (!hit[l] && m_state[l][set][w] != e_coh_i && m_tag[l][set][w] == tag) begin
          hit[l] = 1;
          hway[l] = w;
          hst[l] = m_state[l][set][w];
        end
      end
      if (l != lce && hit[l]) begin
        if (write || hst[l] == e_coh_m) begin
          inv_m[l] = 1'b1;
          exp_q.push_back('{e_cmd_inv, lce_id_width'(l), way_width'(hway[l]), e_coh_i});
        end else begin
          others_left = 1;
          if (hst[l] == e_coh_e) begin
            down_m[l] = 1'b1;
            exp_q.push_back('{e_cmd_set_state, lce_id_width'(l), way_width'(hway[l]), e_coh_s});
          end
        end
      end
    end
    next = write ? e_coh_m : (others_left ? e_coh_s : e_coh_e);
    need_mem = !hit[lce];
    req_way = hit[lce] ? hway[lce] : lru;
    exp_q.push_back('{e_cmd_set_state, lce_id_width'(lce), way_width'(req_way), next});

    @(negedge clk);
    lce_req_v = 1'b1;
    lce_req_lce = lce_id_width'(lce);
    lce_req_addr = addr;
    lce_req_write = write;
    lce_req_lru_way = way_width'(lru);
    cnt = 0;
    #1;
    while (!lce_req_yumi && cnt < wait_limit) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (!lce_req_yumi) begin
      timeout_hit(name, "lce_req_yumi_o");
      return;
    end
    @(negedge clk);
    lce_req_v = 1'b0;

    mem_acc = 0;
    resp_done = 0;
    done = 0;
    lce_hold_v = 0;
    mem_hold_v = 0;
    got_mem = 0;
    got_cmds = 0;
    cnt = 0;
    while (!done && cnt < cmd_limit) begin
      cur = '{lce_cmd_type, lce_cmd_lce, lce_cmd_way, lce_cmd_state};
      if (lce_cmd_v) begin
        if (lce_hold_v && cur != lce_held) report_error(name, "LCE command changed while stalled");
        if (exp_q.size() == 0) begin
          report_error(name, "unexpected LCE command");
        end else begin
          check_value(name, "lce_cmd {type,lce,way,state}", exp_q[0], cur);
          check_value(name, "lce_cmd addr", blk, lce_cmd_addr);
          if (exp_q.size() == 1 && need_mem && !resp_done) begin
            report_error(name, "set-state sent before the memory response");
          end
        end
      end else if (lce_hold_v) begin
        report_error(name, "LCE command dropped while stalled");
      end
      if (mem_cmd_v) begin
        if (!need_mem || mem_acc) report_error(name, "unexpected memory command");
        else if (exp_q.size() != 1) report_error(name, "memory command before sharer commands");
        check_value(name, "mem_cmd addr", blk, mem_cmd_addr);
      end else if (mem_hold_v) begin
        report_error(name, "memory command dropped while stalled");
      end
      lce_rdy = !stall || next_rand() % 2 == 0;
      mem_rdy = !stall || next_rand() % 2 == 0;
      lce_cmd_ready = lce_rdy;
      mem_cmd_ready = mem_rdy;
      mem_resp_v = mem_acc && !resp_done && (!stall || next_rand() % 3 == 0);
      lce_hold_v = lce_cmd_v && !lce_rdy;
      lce_held = cur;
      mem_hold_v = mem_cmd_v && !mem_rdy;
      if (lce_cmd_v && lce_rdy && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        done = (exp_q.size() == 0);
        if (done) begin
          got_state = lce_cmd_state;
          got_way = lce_cmd_way;
        end else begin
          got_cmds++;
        end
      end
      if (mem_cmd_v && mem_rdy) begin
        mem_acc = 1;
        got_mem = 1;
      end
      if (mem_resp_v) begin
        #1;
        if (!mem_resp_yumi) report_error(name, "memory response not consumed");
        resp_done = 1;
      end
      @(negedge clk);
      cnt++;
    end
    lce_cmd_ready = 1'b0;
    mem_cmd_ready = 1'b0;
    mem_resp_v = 1'b0;
    if (!done) begin
      timeout_hit(name, "the requester's set-state command");
      return;
    end
    if (lce_cmd_v || mem_cmd_v) report_error(name, "command after the set-state command");
    if (need_mem && !resp_done) report_error(name, "no memory read on a requester miss");

    for (int l = 0; l < NUM_LCE; l++) begin
      if (inv_m[l]) m_state[l][set][hway[l]] = e_coh_i;
      else if (down_m[l]) m_state[l][set][hway[l]] = e_coh_s;
    end
    m_state[lce][set][req_way] = next;
    m_tag[lce][set][req_way] = tag;
  endtask

  task automatic expect_grant(input string name, input coh_state_e st, input int way,
                              input bit mem, input int cmds);
    check_value(name, "granted state", st, got_state);
    check_value(name, "granted way", way, got_way);
    check_value(name, "memory read", mem, got_mem);
    check_value(name, "sharer commands", cmds, got_cmds);
  endtask

  task automatic test_reset_read_miss();
    check_value("reset", "lce_req_yumi_o", 0, lce_req_yumi);
    check_value("reset", "lce_cmd_v_o", 0, lce_cmd_v);
    check_value("reset", "mem_cmd_v_o", 0, mem_cmd_v);
    check_value("reset", "mem_resp_yumi_o", 0, mem_resp_yumi);
    send_request("read_miss", 0, 16'h1238, 0, 1, 0);
    expect_grant("read_miss", e_coh_e, 1, 1, 0);
  endtask

  task automatic test_sharing();
    // LCE0 holds E in way 1 and is downgraded
    send_request("sharing", 1, 16'h1238, 0, 0, 0);
    expect_grant("sharing", e_coh_s, 0, 1, 1);
    send_request("third_sharer", 2, 16'h123c, 0, 1, 0);
    expect_grant("third_sharer", e_coh_s, 1, 1, 0);
  endtask

  task automatic test_write_upgrade();
    send_request("write_upgrade", 1, 16'h1238, 1, 1, 0);
    expect_grant("write_upgrade", e_coh_m, 0, 0, 2);
    send_request("read_after_m", 0, 16'h1238, 0, 0, 0);
    expect_grant("read_after_m", e_coh_e, 0, 1, 1);
  endtask

  task automatic test_replacement();
    send_request("set0_fill", 3, 16'h4000, 0, 0, 0);
    expect_grant("set0_fill", e_coh_e, 0, 1, 0);
    send_request("set1_fill", 3, 16'h4008, 0, 0, 0);
    expect_grant("set1_fill", e_coh_e, 0, 1, 0);
    // Same set and victim way, so 0x4000 leaves LCE3
    send_request("victim_reuse", 3, 16'h8000, 0, 0, 0);
    expect_grant("victim_reuse", e_coh_e, 0, 1, 0);
    send_request("old_block", 2, 16'h4000, 0, 1, 0);
    expect_grant("old_block", e_coh_e, 1, 1, 0);
    send_request("other_set", 2, 16'h4008, 0, 0, 0);
    expect_grant("other_set", e_coh_s, 0, 1, 1);
  endtask

  task automatic test_random_traffic();
    logic [15:0] addr;
    int          lce;
    bit          write;
    int          lru;
    for (int i = 0; i < 200; i++) begin
      // Small tag and set pool so blocks are shared often
      addr = 16'((next_rand() % 4) << 6) | 16'((next_rand() % 2) << 3) | 16'(next_rand() % 8);
      lce = next_rand() % NUM_LCE;
      write = (next_rand() % 3 == 0);
      lru = next_rand() % LCE_ASSOC;
      send_request($sformatf("random_%0d", i), lce, addr, write, lru, 1);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  initial begin
    arst_n = 1'b0;
    lce_req_v = 1'b0;
    lce_req_lce = '0;
    lce_req_addr = '0;
    lce_req_write = 1'b0;
    lce_req_lru_way = '0;
    lce_cmd_ready = 1'b0;
    mem_cmd_ready = 1'b0;
    mem_resp_v = 1'b0;
    for (int l = 0; l < NUM_LCE; l++) begin
      for (int s = 0; s < LCE_SETS; s++) begin
        for (int w = 0; w < LCE_ASSOC; w++) begin
          m_state[l][s][w] = e_coh_i;
          m_tag[l][s][w] = '0;
        end
      end
    end
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_reset_read_miss();
    test_sharing();
    test_write_upgrade();
    test_replacement();
    test_random_traffic();
    finish_run();
  end

endmodule
